/* src/lcd_pkg.sv */
package lcd_pkg;

  // clk cycles per serial bit tick
  localparam int CLK_DIV = 4;
  // divider counter width, holds 0 .. CLK_DIV-1
  localparam int DIV_W = 3;

  // delay counter width and the two delays, in ticks
  localparam int DELAY_W = 8;
  localparam logic [DELAY_W-1:0] POWER_DELAY_TICKS = 8'd40;
  localparam logic [DELAY_W-1:0] CMD_DELAY_TICKS = 8'd24;

  // number of power-on commands in the init table
  localparam int INIT_LEN = 3;

  // panel opcodes used by this driver
  typedef enum logic [7:0] {
    SWRESET = 8'h01,
    SLPOUT  = 8'h11,
    INVOFF  = 8'h20,
    INVON   = 8'h21,
    DISPON  = 8'h29
  } lcd_opcode_e;

  typedef enum logic [2:0] {
    S_POWER_WAIT,
    S_SEND_INIT,
    S_INIT_WAIT,
    S_IDLE,
    S_HOST_SEND,
    S_HOST_ACK
  } seq_state_e;

  // one byte on the serial bus, is_cmd set drives rs_dc low
  typedef struct packed {
    logic       is_cmd;
    logic [7:0] data;
  } lcd_packet_t;

  // init table, SWRESET then SLPOUT then DISPON
  function automatic lcd_opcode_e init_opcode(input logic [1:0] idx);
    lcd_opcode_e op;
    case (idx)
      2'd0:    op = SWRESET;
      2'd1:    op = SLPOUT;
      default: op = DISPON;
    endcase
    return op;
  endfunction

endpackage

/* src/lcd_timer.sv */
`timescale 1ns/10ps

module lcd_timer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        delay_load,
  input  logic [lcd_pkg::DELAY_W-1:0] delay_ticks,
  output logic                        tick,
  output logic                        delay_done
);

  import lcd_pkg::*;

  // free-running divider position
  logic [DIV_W-1:0]   div_cnt;
  // remaining settle delay in ticks
  logic [DELAY_W-1:0] delay_cnt;

  // tick is a one-clk pulse, once per CLK_DIV clks
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end
    else
    begin
      if (div_cnt == DIV_W'(CLK_DIV - 1))
      begin
        div_cnt <= '0;
        tick    <= 1'b1;
      end
      else
      begin
        div_cnt <= div_cnt + 1'b1;
        tick    <= 1'b0;
      end
    end
  end

  // down-counter, starts with the power-on delay
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      delay_cnt <= POWER_DELAY_TICKS;
    end
    else if (delay_load)
    begin
      delay_cnt <= delay_ticks;
    end
    else if (tick && (delay_cnt != '0))
    begin
      // counts only on bit ticks, parks at zero
      delay_cnt <= delay_cnt - 1'b1;
    end
  end

  // level, high as long as the counter sits at zero
  assign delay_done = (delay_cnt == '0);

endmodule

/* src/spi_shifter.sv */
`timescale 1ns/10ps

module spi_shifter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 tick,
  input  logic                 tx_start,
  input  lcd_pkg::lcd_packet_t tx_pkt,
  output logic                 tx_busy,
  output logic                 sck,
  output logic                 data,
  output logic                 rs_dc,
  output logic                 cs
);

  import lcd_pkg::*;

  // byte held for the whole transfer
  lcd_packet_t pkt_q;
  // bit currently on the data pin
  logic [2:0]  bit_idx;
  // 0 while sck low, 1 while sck high
  logic        phase;
  // trailing low tick after bit 0, cs rises next
  logic        tail;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tx_busy <= 1'b0;
      cs      <= 1'b1;
      sck     <= 1'b0;
      data    <= 1'b0;
      rs_dc   <= 1'b0;
      bit_idx <= 3'd7;
      phase   <= 1'b0;
      tail    <= 1'b0;
    end
    else if (!tx_busy)
    begin
      // new byte only accepted between transfers
      if (tx_start)
      begin
        tx_busy <= 1'b1;
        bit_idx <= 3'd7;
        phase   <= 1'b0;
        tail    <= 1'b0;
      end
    end
    else if (tick)
    begin
      if (cs)
      begin
        // first tick, select the panel and set up the MSB
        cs    <= 1'b0;
        sck   <= 1'b0;
        rs_dc <= ~pkt_q.is_cmd;
        data  <= pkt_q.data[7];
      end
      else if (tail)
      begin
        // deselect, transfer over
        cs      <= 1'b1;
        tx_busy <= 1'b0;
        tail    <= 1'b0;
      end
      else if (!phase)
      begin
        // rising edge, panel samples here
        sck   <= 1'b1;
        phase <= 1'b1;
      end
      else
      begin
        // falling edge, bus only changes while sck is low
        sck   <= 1'b0;
        phase <= 1'b0;
        if (bit_idx == 3'd0)
        begin
          tail <= 1'b1;
        end
        else
        begin
          bit_idx <= bit_idx - 3'd1;
          data    <= pkt_q.data[bit_idx - 3'd1];
        end
      end
    end
  end

  // payload latch
  always_ff @(posedge clk)
  begin
    if (tx_start && !tx_busy)
    begin
      pkt_q <= tx_pkt;
    end
  end

endmodule

/* src/lcd_sequencer.sv */
`timescale 1ns/10ps

module lcd_sequencer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        tick,
  input  logic                        delay_done,
  input  logic                        tx_busy,
  input  logic                        host_req,
  input  lcd_pkg::lcd_packet_t        host_pkt,
  output logic                        delay_load,
  output logic [lcd_pkg::DELAY_W-1:0] delay_ticks,
  output logic                        tx_start,
  output lcd_pkg::lcd_packet_t        tx_pkt,
  output logic                        host_ack,
  output logic                        ready,
  output logic                        inv
);

  import lcd_pkg::*;

  seq_state_e state;
  // position in the init table
  logic [1:0] init_idx;
  // tx_start already issued for the current byte
  logic       tx_launched;
  // byte handed over earlier and shifter idle again
  logic       tx_done;
  logic       init_last;
  logic       send_state;

  assign send_state = (state == S_SEND_INIT) || (state == S_HOST_SEND);
  assign init_last  = (init_idx == 2'(INIT_LEN - 1));
  assign tx_done    = tx_launched && !tx_busy;

  // one pulse per byte, never while the shifter is busy
  assign tx_start = send_state && !tx_launched && !tx_busy;

  // settle delay armed as soon as an init command is out
  assign delay_load  = (state == S_SEND_INIT) && tx_done;
  assign delay_ticks = CMD_DELAY_TICKS;

  // host byte in host states, otherwise the current init command
  always_comb
  begin
    if (state == S_HOST_SEND)
    begin
      tx_pkt = host_pkt;
    end
    else
    begin
      tx_pkt.is_cmd = 1'b1;
      tx_pkt.data   = init_opcode(init_idx);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state       <= S_POWER_WAIT;
      init_idx    <= 2'd0;
      tx_launched <= 1'b0;
      host_ack    <= 1'b0;
      ready       <= 1'b0;
      inv         <= 1'b0;
    end
    else
    begin
      if (tx_start)
      begin
        tx_launched <= 1'b1;
      end
      case (state)
        S_POWER_WAIT:
        begin
          // steps on tick boundaries once the power-on delay is out
          if (tick && delay_done)
          begin
            state <= S_SEND_INIT;
          end
        end
        S_SEND_INIT:
        begin
          if (tx_done)
          begin
            tx_launched <= 1'b0;
            state       <= S_INIT_WAIT;
          end
        end
        S_INIT_WAIT:
        begin
          if (tick && delay_done)
          begin
            if (init_last)
            begin
              ready <= 1'b1;
              state <= S_IDLE;
            end
            else
            begin
              init_idx <= init_idx + 2'd1;
              state    <= S_SEND_INIT;
            end
          end
        end
        S_IDLE:
        begin
          // requests raised during init are picked up here
          if (host_req)
          begin
            state <= S_HOST_SEND;
          end
        end
        S_HOST_SEND:
        begin
          // inversion follows the command as it goes out
          if (tx_start && host_pkt.is_cmd)
          begin
            if (host_pkt.data == INVON)
            begin
              inv <= 1'b1;
            end
            else if (host_pkt.data == INVOFF)
            begin
              inv <= 1'b0;
            end
          end
          // ack one clk after cs is back high
          if (tx_done)
          begin
            tx_launched <= 1'b0;
            host_ack    <= 1'b1;
            state       <= S_HOST_ACK;
          end
        end
        S_HOST_ACK:
        begin
          // hold ack until the host lets go
          if (!host_req)
          begin
            host_ack <= 1'b0;
            state    <= S_IDLE;
          end
        end
        default:
        begin
          state <= S_POWER_WAIT;
        end
      endcase
    end
  end

endmodule

/* src/lcd_top.sv */
`timescale 1ns/10ps

module lcd_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 host_req,
  input  lcd_pkg::lcd_packet_t host_pkt,
  output logic                 host_ack,
  output logic                 ready,
  output logic                 inv,
  output logic                 sck,
  output logic                 data,
  output logic                 rs_dc,
  output logic                 cs
);

  import lcd_pkg::*;

  // shared bit tick
  logic               tick;
  // settle delay control
  logic               delay_load;
  logic [DELAY_W-1:0] delay_ticks;
  logic               delay_done;
  // sequencer to shifter
  logic               tx_start;
  lcd_packet_t        tx_pkt;
  logic               tx_busy;

  lcd_timer timer0 (
    .clk         (clk),
    .rst         (rst),
    .delay_load  (delay_load),
    .delay_ticks (delay_ticks),
    .tick        (tick),
    .delay_done  (delay_done)
  );

  lcd_sequencer seq0 (
    .clk         (clk),
    .rst         (rst),
    .tick        (tick),
    .delay_done  (delay_done),
    .tx_busy     (tx_busy),
    .host_req    (host_req),
    .host_pkt    (host_pkt),
    .delay_load  (delay_load),
    .delay_ticks (delay_ticks),
    .tx_start    (tx_start),
    .tx_pkt      (tx_pkt),
    .host_ack    (host_ack),
    .ready       (ready),
    .inv         (inv)
  );

  // panel pins come straight from the shifter
  spi_shifter shift0 (
    .clk      (clk),
    .rst      (rst),
    .tick     (tick),
    .tx_start (tx_start),
    .tx_pkt   (tx_pkt),
    .tx_busy  (tx_busy),
    .sck      (sck),
    .data     (data),
    .rs_dc    (rs_dc),
    .cs       (cs)
  );

endmodule

/* tests/tb_lcd_top.sv */
`timescale 1ns/10ps

module tb_lcd_top;

  import lcd_pkg::*;

  localparam int NUM_PKTS    = 40;
  localparam int READY_LIMIT = 3000;
  localparam int ACK_LIMIT   = 500;

  logic        clk;
  logic        rst;
  logic        host_req;
  lcd_packet_t host_pkt;
  logic        host_ack;
  logic        ready;
  logic        inv;
  logic        sck;
  logic        data;
  logic        rs_dc;
  logic        cs;

  // reference model state
  lcd_packet_t exp_q[$];
  lcd_packet_t rx_q[$];
  logic        exp_inv;
  int          seed;

  // bus monitor state
  logic [7:0]  shreg;
  logic        dc_seen;
  int          bit_cnt;
  int          rx_total;
  int          ack_rises;
  logic        prev_sck;
  logic        prev_cs;
  logic        prev_ack;
  logic        prev_req;
  logic        prev_ready;

  lcd_top dut0 (
    .clk      (clk),
    .rst      (rst),
    .host_req (host_req),
    .host_pkt (host_pkt),
    .host_ack (host_ack),
    .ready    (ready),
    .inv      (inv),
    .sck      (sck),
    .data     (data),
    .rs_dc    (rs_dc),
    .cs       (cs)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_packet(input string name, input lcd_packet_t exp,
                              input lcd_packet_t act);
    if (exp !== act)
    begin
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // random tag and byte with the inversion opcodes mixed in
  task automatic make_packet(output lcd_packet_t p);
    int r;
    r = $random(seed);
    p.is_cmd = r[0];
    p.data   = r[15:8];
    if (p.is_cmd && ($unsigned(r) % 3 == 0))
      p.data = r[1] ? INVON : INVOFF;
    else if (!p.is_cmd && (r[3:2] == 2'b00))
      // data bytes that look like INVON/INVOFF
      p.data = r[1] ? 8'h21 : 8'h20;
  endtask

  task automatic wait_ready();
    int n;
    for (n = 0; n < READY_LIMIT; n++)
    begin
      @(negedge clk);
      if (ready)
        return;
    end
    report_failure("timeout: ready never rose after the power-on sequence");
  endtask

  task automatic wait_ack(input logic level);
    int n;
    for (n = 0; n < ACK_LIMIT; n++)
    begin
      @(negedge clk);
      if (host_ack === level)
        return;
    end
    report_failure($sformatf("timeout: host_ack never went to %b", level));
  endtask

  task automatic wait_drain();
    int n;
    for (n = 0; n < ACK_LIMIT; n++)
    begin
      if (rx_q.size() >= exp_q.size())
        return;
      @(negedge clk);
    end
    report_failure("timeout: bytes still missing on the serial bus");
  endtask

  // oldest received byte against oldest expected byte
  task automatic compare_next();
    lcd_packet_t e;
    lcd_packet_t a;
    if (rx_q.size() == 0)
    begin
      report_failure("no byte seen on the serial bus where one was expected");
    end
    else
    begin
      e = exp_q.pop_front();
      a = rx_q.pop_front();
      check_packet("bus_packet", e, a);
    end
  endtask

  // serial bus monitor on the clk edge
  always @(posedge clk)
  begin
    if (rst)
    begin
      prev_sck   = 1'b0;
      prev_cs    = 1'b1;
      prev_ack   = 1'b0;
      prev_req   = 1'b0;
      prev_ready = 1'b0;
      bit_cnt    = 0;
    end
    else
    begin
      // panel samples on rising sck
      if (!cs && sck && !prev_sck)
      begin
        shreg   = {shreg[6:0], data};
        dc_seen = rs_dc;
        bit_cnt = bit_cnt + 1;
      end
      // end of byte
      if (cs && !prev_cs)
      begin
        check_bit("eight_bits_per_byte", 1'b1, bit_cnt == 8);
        rx_q.push_back('{is_cmd: ~dc_seen, data: shreg});
        rx_total = rx_total + 1;
        bit_cnt  = 0;
      end
      if (host_ack && !prev_ack)
      begin
        ack_rises = ack_rises + 1;
        check_bit("cs", 1'b1, cs);
        check_bit("byte_received", 1'b1, rx_total == INIT_LEN + ack_rises);
      end
      // ack only drops once the host has let go
      if (!host_ack && prev_ack)
        check_bit("host_req", 1'b0, prev_req);
      if (ready && !prev_ready)
        check_bit("init_bytes_done", 1'b1, rx_total == INIT_LEN);
      prev_sck   = sck;
      prev_cs    = cs;
      prev_ack   = host_ack;
      prev_req   = host_req;
      prev_ready = ready;
    end
  end

  initial
  begin
    lcd_packet_t pkt;
    int i;
    int hold;
    seed      = 76;
    rst       = 1'b1;
    host_req  = 1'b0;
    host_pkt  = '0;
    exp_inv   = 1'b0;
    rx_total  = 0;
    ack_rises = 0;
    shreg     = '0;
    dc_seen   = 1'b0;
    // power-on commands come first
    exp_q.push_back('{is_cmd: 1'b1, data: SWRESET});
    exp_q.push_back('{is_cmd: 1'b1, data: SLPOUT});
    exp_q.push_back('{is_cmd: 1'b1, data: DISPON});
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_bit("cs", 1'b1, cs);
    check_bit("sck", 1'b0, sck);
    check_bit("host_ack", 1'b0, host_ack);
    check_bit("ready", 1'b0, ready);
    check_bit("inv", 1'b0, inv);
    for (i = 0; i < NUM_PKTS; i++)
    begin
      make_packet(pkt);
      host_pkt = pkt;
      host_req = 1'b1;
      exp_q.push_back(pkt);
      if (pkt.is_cmd && (pkt.data == INVON))
        exp_inv = 1'b1;
      else if (pkt.is_cmd && (pkt.data == INVOFF))
        exp_inv = 1'b0;
      // first request is raised during init and must be held
      if (i == 0)
      begin
        wait_ready();
        repeat (INIT_LEN) compare_next();
      end
      wait_ack(1'b1);
      compare_next();
      check_bit("inv", exp_inv, inv);
      // request held a few more clks while ack stays high
      hold = $random(seed) & 3;
      repeat (hold)
      begin
        @(negedge clk);
        check_bit("host_ack", 1'b1, host_ack);
      end
      host_req = 1'b0;
      wait_ack(1'b0);
    end
    wait_drain();
    if ((rx_q.size() == 0) && (exp_q.size() == 0))
    begin
      $display("RESULT: PASS");
      $finish;
    end
    else
    begin
      $display("received and expected byte counts differ at the end of the run");
      $display("RESULT: FAIL");
      $fatal(1);
    end
  end

endmodule

/* build.f */
src/lcd_pkg.sv
src/lcd_timer.sv
src/spi_shifter.sv
src/lcd_sequencer.sv
src/lcd_top.sv
tests/tb_lcd_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lcd_top
DUT_TOP   ?= lcd_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) \
		src/lcd_pkg.sv src/lcd_timer.sv src/spi_shifter.sv \
		src/lcd_sequencer.sv src/lcd_top.sv

clean:
	rm -rf $(OBJ_DIR)
